/* dbg_test.f */
src/dbg_test_pkg.sv
src/dbg_test_jtagsm.sv
src/dbg_test_dr_bank.sv
src/dbg_test_top.sv
verification/dbg_test_props.sv
verification/dbg_test_tb.sv

/* Makefile */
# Verilator build and run of the JTAG debug-test access port

TOP := dbg_test_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f dbg_test.f -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

lint:
	verilator --lint-only -Wall --top-module dbg_test_top \
		src/dbg_test_pkg.sv src/dbg_test_jtagsm.sv \
		src/dbg_test_dr_bank.sv src/dbg_test_top.sv

clean:
	rm -rf obj_dir sim.log

/* verification/dbg_test_tb.sv */
//////////////////////////////////////////////////////////////////////
// Clock, reset, random JTAG sequences and a TAP model for the DUT
//////////////////////////////////////////////////////////////////////

module dbg_test_tb
  import dbg_test_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          TOTAL_IR_SIZE = 15;
  localparam int          DATA_WIDTH    = 32;
  localparam logic [31:0] IDCODE_VALUE  = 32'h1dbe_0f35;

  logic tck;
  logic reset_n;
  logic tms;
  logic tdi;
  logic tdo;
  logic [DATA_WIDTH-1:0] data_in;
  logic [DATA_WIDTH-1:0] data_out;
  logic data_strobe;
  instr_t instruction;
  logic shift_dr_next;

  logic [31:0] lfsr;
  int strobe_count;
  logic last_tdo;

  // Reference model of the TAP and its registers
  tap_state_t m_state;
  logic [TOTAL_IR_SIZE-1:0] m_ir;
  instr_t m_instr;
  logic [31:0] m_idcode;
  logic [31:0] m_data;
  logic [31:0] m_data_out;
  logic m_bypass;

  dbg_test_top #(
    .TOTAL_IR_SIZE (TOTAL_IR_SIZE),
    .DATA_WIDTH    (DATA_WIDTH),
    .IDCODE_VALUE  (IDCODE_VALUE)
  ) uut (
    .tck           (tck),
    .reset_n       (reset_n),
    .tms           (tms),
    .tdi           (tdi),
    .tdo           (tdo),
    .data_in       (data_in),
    .data_out      (data_out),
    .data_strobe   (data_strobe),
    .instruction   (instruction),
    .shift_dr_next (shift_dr_next)
  );

  always #20 tck = ~tck;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // IDCODE, DATA or any other code, which means BYPASS
  function automatic instr_t random_code();
    logic [31:0] r;
    r = rand_bits(2);
    if (r == 32'd0)
      return INSTR_IDCODE;
    if (r == 32'd1)
      return INSTR_DATA;
    r = rand_bits(INSTR_WIDTH);
    return r[INSTR_WIDTH-1:0];
  endfunction

  function automatic tap_state_t tap_next(input tap_state_t s, input logic t);
    case (s)
      TAP_TEST_LOGIC_RESET: return t ? TAP_TEST_LOGIC_RESET : TAP_RUN_TEST_IDLE;
      TAP_RUN_TEST_IDLE:    return t ? TAP_SELECT_DR_SCAN : TAP_RUN_TEST_IDLE;
      TAP_SELECT_DR_SCAN:   return t ? TAP_SELECT_IR_SCAN : TAP_CAPTURE_DR;
      TAP_CAPTURE_DR:       return t ? TAP_EXIT1_DR : TAP_SHIFT_DR;
      TAP_SHIFT_DR:         return t ? TAP_EXIT1_DR : TAP_SHIFT_DR;
      TAP_EXIT1_DR:         return t ? TAP_UPDATE_DR : TAP_PAUSE_DR;
      TAP_PAUSE_DR:         return t ? TAP_EXIT2_DR : TAP_PAUSE_DR;
      TAP_EXIT2_DR:         return t ? TAP_UPDATE_DR : TAP_SHIFT_DR;
      TAP_UPDATE_DR:        return t ? TAP_SELECT_DR_SCAN : TAP_RUN_TEST_IDLE;
      TAP_SELECT_IR_SCAN:   return t ? TAP_TEST_LOGIC_RESET : TAP_CAPTURE_IR;
      TAP_CAPTURE_IR:       return t ? TAP_EXIT1_IR : TAP_SHIFT_IR;
      TAP_SHIFT_IR:         return t ? TAP_EXIT1_IR : TAP_SHIFT_IR;
      TAP_EXIT1_IR:         return t ? TAP_UPDATE_IR : TAP_PAUSE_IR;
      TAP_PAUSE_IR:         return t ? TAP_EXIT2_IR : TAP_PAUSE_IR;
      TAP_EXIT2_IR:         return t ? TAP_UPDATE_IR : TAP_SHIFT_IR;
      TAP_UPDATE_IR:        return t ? TAP_SELECT_DR_SCAN : TAP_RUN_TEST_IDLE;
      default:              return TAP_TEST_LOGIC_RESET;
    endcase
  endfunction

  function automatic logic expected_tdo();
    if (m_state == TAP_SHIFT_IR)
      return m_ir[0];
    if (m_instr == INSTR_IDCODE)
      return m_idcode[0];
    if (m_instr == INSTR_DATA)
      return m_data[0];
    return m_bypass;
  endfunction

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual)
    begin
      fail_stop($sformatf("MISMATCH at %0t: %s expected %h actual %h",
                          $realtime, name, expected, actual));
    end
  endtask

  // Polled from half-nanosecond offsets so no poll lands on a clock edge
  task automatic wait_clock(input logic level, input string what);
    int n;
    n = 0;
    while (tck !== level)
    begin
      #1;
      n++;
      if (n > 50)
        fail_stop($sformatf("Timeout: tck never reached the %s", what));
    end
  endtask

  // Falling-edge effects first, then the comparison just before the rise
  task automatic sample_outputs();
    logic exp_strobe;
    if (m_state == TAP_UPDATE_IR)
      m_instr = m_ir[INSTR_WIDTH-1:0];
    exp_strobe = (m_state == TAP_UPDATE_DR) && (m_instr == INSTR_DATA);
    if (exp_strobe)
      m_data_out = m_data;
    compare("test_logic_reset", 32'(m_state == TAP_TEST_LOGIC_RESET),
            32'(uut.u_jtagsm.ctrl.test_logic_reset));
    compare("shift_dr_next", 32'(tap_next(m_state, tms) == TAP_SHIFT_DR),
            32'(shift_dr_next));
    compare("instruction", 32'(m_instr), 32'(instruction));
    compare("data_out", m_data_out, data_out);
    compare("data_strobe", 32'(exp_strobe), 32'(data_strobe));
    if (m_state == TAP_SHIFT_IR || m_state == TAP_SHIFT_DR)
      compare("tdo", 32'(expected_tdo()), 32'(tdo));
    if (data_strobe === 1'b1)
      strobe_count++;
    last_tdo = tdo;
  endtask

  task automatic update_model(input logic t_ms, input logic t_di);
    case (m_state)
      TAP_TEST_LOGIC_RESET: m_ir = '0;
      TAP_SHIFT_IR:         m_ir = {t_di, m_ir[TOTAL_IR_SIZE-1:1]};
      TAP_CAPTURE_DR:
        if (m_instr == INSTR_IDCODE)
          m_idcode = IDCODE_VALUE;
        else if (m_instr == INSTR_DATA)
          m_data = data_in;
        else
          m_bypass = 1'b0;
      TAP_SHIFT_DR:
        if (m_instr == INSTR_IDCODE)
          m_idcode = {t_di, m_idcode[31:1]};
        else if (m_instr == INSTR_DATA)
          m_data = {t_di, m_data[31:1]};
        else
          m_bypass = t_di;
      default: ;
    endcase
    m_state = tap_next(m_state, t_ms);
  endtask

  // Entered and left 2 ns after a rising edge
  task automatic jtag_cycle(input logic t_ms, input logic t_di);
    tms = t_ms;
    tdi = t_di;
    #0.5;
    wait_clock(1'b0, "low phase");
    #18;
    sample_outputs();
    wait_clock(1'b1, "rising edge");
    update_model(t_ms, t_di);
    #1.5;
  endtask

  task automatic load_instruction(input instr_t code);
    logic [31:0] r;
    logic [TOTAL_IR_SIZE-1:0] word;
    r = rand_bits(TOTAL_IR_SIZE);
    word = r[TOTAL_IR_SIZE-1:0];
    word[INSTR_WIDTH-1:0] = code;
    jtag_cycle(1'b1, 1'b0);
    jtag_cycle(1'b1, 1'b0);
    jtag_cycle(1'b0, 1'b0);
    jtag_cycle(1'b0, 1'b0);
    for (int i = 0; i < TOTAL_IR_SIZE; i++)
      jtag_cycle(i == TOTAL_IR_SIZE - 1, word[i]);
    jtag_cycle(1'b1, 1'b0);
    jtag_cycle(1'b0, 1'b0);
    compare("loaded instruction", 32'(code), 32'(instruction));
  endtask

  task automatic dr_scan();
    logic [31:0] sent;
    logic [31:0] got;
    logic [31:0] captured;
    logic [31:0] old_out;
    logic [31:0] mask;
    int len;
    int pause_at;
    int strobes_before;
    sent = rand_bits(32);
    data_in = rand_bits(32);
    captured = data_in;
    old_out = data_out;
    got = '0;
    mask = '0;
    if (m_instr == INSTR_IDCODE || m_instr == INSTR_DATA)
      len = 32;
    else
      len = 2 + int'(rand_bits(4));
    pause_at = int'(rand_bits(5));
    strobes_before = strobe_count;
    jtag_cycle(1'b1, 1'b0);
    jtag_cycle(1'b0, 1'b0);
    jtag_cycle(1'b0, 1'b0);
    for (int i = 0; i < len; i++)
    begin
      jtag_cycle((i == len - 1) || (i == pause_at), sent[i]);
      got[i] = last_tdo;
      mask[i] = 1'b1;
      if (i == pause_at && i != len - 1)
      begin
        // Detour through Pause-DR and back into Shift-DR
        jtag_cycle(1'b0, 1'b0);
        jtag_cycle(1'b0, 1'b0);
        jtag_cycle(1'b1, 1'b0);
        jtag_cycle(1'b0, 1'b0);
      end
    end
    jtag_cycle(1'b1, 1'b0);
    jtag_cycle(1'b0, 1'b0);
    if (m_instr == INSTR_DATA)
    begin
      compare("data scan", captured, got);
      compare("data_out", sent, data_out);
      compare("data_strobe pulses", 32'd1, 32'(strobe_count - strobes_before));
    end
    else
    begin
      compare("data_out held", old_out, data_out);
      compare("data_strobe pulses", 32'd0, 32'(strobe_count - strobes_before));
      if (m_instr == INSTR_IDCODE)
        compare("idcode scan", IDCODE_VALUE, got);
      else
        compare("bypass scan", (sent << 1) & mask, got);
    end
  endtask

  task automatic random_walk();
    logic [31:0] n;
    logic [31:0] r;
    n = 32'd4 + rand_bits(4);
    for (int i = 0; i < int'(n); i++)
    begin
      r = rand_bits(2);
      jtag_cycle(r[0], r[1]);
    end
    repeat (5) jtag_cycle(1'b1, 1'b0);
    compare("test_logic_reset", 32'd1, 32'(uut.u_jtagsm.ctrl.test_logic_reset));
    jtag_cycle(1'b0, 1'b0);
  endtask

  initial
  begin
    logic [31:0] sel;
    tck = 1'b0;
    reset_n = 1'b0;
    tms = 1'b1;
    tdi = 1'b0;
    data_in = '0;
    lfsr = 32'h89c6_fafd;
    strobe_count = 0;
    last_tdo = 1'b0;
    m_state = TAP_TEST_LOGIC_RESET;
    m_ir = '0;
    m_instr = '0;
    m_idcode = '0;
    m_data = '0;
    m_data_out = '0;
    m_bypass = 1'b0;
    #0.5;
    repeat (16)
    begin
      wait_clock(1'b0, "low phase in reset");
      wait_clock(1'b1, "rising edge in reset");
    end
    #1.5;
    reset_n = 1'b1;
    compare("instruction", 32'd0, 32'(instruction));
    compare("data_out", 32'd0, data_out);
    compare("data_strobe", 32'd0, 32'(data_strobe));
    compare("test_logic_reset", 32'd1, 32'(uut.u_jtagsm.ctrl.test_logic_reset));
    jtag_cycle(1'b0, 1'b0);
    // Reset instruction 0 selects BYPASS
    dr_scan();
    load_instruction(INSTR_IDCODE);
    dr_scan();
    load_instruction(INSTR_DATA);
    dr_scan();
    random_walk();
    for (int op = 0; op < 80; op++)
    begin
      sel = rand_bits(3);
      if (sel < 32'd3)
        load_instruction(random_code());
      else if (sel < 32'd7)
        dr_scan();
      else
        random_walk();
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* verification/dbg_test_props.sv */
//////////////////////////////////////////////////////////////////////
// Assertions on the TAP control bundle, bound to the TAP controller
//////////////////////////////////////////////////////////////////////

module dbg_test_props
  import dbg_test_pkg::*;
(
  input logic      tck,
  input logic      reset_n,
  input logic      tms,
  input tap_ctrl_t ctrl
);

  timeunit 1ns;
  timeprecision 100ps;

  property one_shift_at_most;
    @(posedge tck) disable iff (!reset_n)
      !(ctrl.shift_ir && ctrl.shift_dr);
  endproperty

  property updates_exclusive;
    @(posedge tck) disable iff (!reset_n)
      !(ctrl.update_ir && ctrl.update_dr);
  endproperty

  // Five tms-high edges reach Test-Logic-Reset from any state
  property tms_high_resets;
    @(posedge tck) disable iff (!reset_n)
      tms ##1 tms ##1 tms ##1 tms ##1 tms |=> ctrl.test_logic_reset;
  endproperty

  assert property (one_shift_at_most)
    else $error("shift_ir and shift_dr are high together");
  assert property (updates_exclusive)
    else $error("update_ir and update_dr are high together");
  assert property (tms_high_resets)
    else $error("five cycles of tms high did not reach Test-Logic-Reset");

endmodule

bind dbg_test_jtagsm dbg_test_props u_props (
  .tck     (tck),
  .reset_n (reset_n),
  .tms     (tms),
  .ctrl    (ctrl)
);

/* src/dbg_test_top.sv */
//////////////////////////////////////////////////////////////////////
// JTAG debug-test access port top level
//////////////////////////////////////////////////////////////////////

module dbg_test_top
  import dbg_test_pkg::*;
#(
  parameter int          TOTAL_IR_SIZE = 15,
  parameter int          DATA_WIDTH    = 32,
  parameter logic [31:0] IDCODE_VALUE  = 32'h1dbe_0f35
) (
  input  logic                  tck,
  input  logic                  reset_n,
  input  logic                  tms,
  input  logic                  tdi,
  output logic                  tdo,
  input  logic [DATA_WIDTH-1:0] data_in,
  output logic [DATA_WIDTH-1:0] data_out,
  output logic                  data_strobe,
  output instr_t                instruction,
  output logic                  shift_dr_next
);

  tap_ctrl_t ctrl;
  logic      ir_tdo;

  dbg_test_jtagsm #(
    .TOTAL_IR_SIZE (TOTAL_IR_SIZE)
  ) u_jtagsm (
    .tck           (tck),
    .reset_n       (reset_n),
    .tms           (tms),
    .tdi           (tdi),
    .ctrl          (ctrl),
    .instruction   (instruction),
    .ir_tdo        (ir_tdo),
    .shift_dr_next (shift_dr_next)
  );

  dbg_test_dr_bank #(
    .DATA_WIDTH   (DATA_WIDTH),
    .IDCODE_VALUE (IDCODE_VALUE)
  ) u_dr_bank (
    .tck         (tck),
    .reset_n     (reset_n),
    .tdi         (tdi),
    .ctrl        (ctrl),
    .instruction (instruction),
    .ir_tdo      (ir_tdo),
    .data_in     (data_in),
    .tdo         (tdo),
    .data_out    (data_out),
    .data_strobe (data_strobe)
  );

endmodule

/* src/dbg_test_dr_bank.sv */
//////////////////////////////////////////////////////////////////////
// Data register bank: instruction decode, IDCODE, BYPASS and user
// DATA registers, parallel DATA update and tdo select
//////////////////////////////////////////////////////////////////////

module dbg_test_dr_bank
  import dbg_test_pkg::*;
#(
  parameter int          DATA_WIDTH   = 32,
  parameter logic [31:0] IDCODE_VALUE = 32'h1dbe_0f35
) (
  input  logic                  tck,
  input  logic                  reset_n,
  input  logic                  tdi,
  input  tap_ctrl_t             ctrl,
  input  instr_t                instruction,
  input  logic                  ir_tdo,
  input  logic [DATA_WIDTH-1:0] data_in,
  output logic                  tdo,
  output logic [DATA_WIDTH-1:0] data_out,
  output logic                  data_strobe
);

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [31:0]           idcode_t;

  logic sel_idcode;
  logic sel_data;
  logic sel_bypass;

  idcode_t idcode_sr;
  data_t   data_sr;
  logic    bypass_sr;

  // BYPASS takes every unassigned code
  assign sel_idcode = (instruction == INSTR_IDCODE);
  assign sel_data   = (instruction == INSTR_DATA);
  assign sel_bypass = !sel_idcode && !sel_data;

  always_ff @(posedge tck)
  begin
    if (sel_idcode)
    begin
      if (ctrl.capture_dr)
        idcode_sr <= IDCODE_VALUE;
      else if (ctrl.shift_dr)
        idcode_sr <= {tdi, idcode_sr[31:1]};
    end
  end

  always_ff @(posedge tck)
  begin
    if (sel_data)
    begin
      if (ctrl.capture_dr)
        data_sr <= data_in;
      else if (ctrl.shift_dr)
        data_sr <= {tdi, data_sr[DATA_WIDTH-1:1]};
    end
  end

  // Single stage, so a scan returns a leading 0 and then tdi
  always_ff @(posedge tck)
  begin
    if (sel_bypass)
    begin
      if (ctrl.capture_dr)
        bypass_sr <= 1'b0;
      else if (ctrl.shift_dr)
        bypass_sr <= tdi;
    end
  end

  // Parallel DATA update on the falling edge in Update-DR
  always_ff @(negedge tck or negedge reset_n)
  begin
    if (!reset_n)
    begin
      data_out    <= '0;
      data_strobe <= 1'b0;
    end
    else
    begin
      data_strobe <= ctrl.update_dr && sel_data;
      if (ctrl.update_dr && sel_data)
        data_out <= data_sr;
    end
  end

  always_comb
  begin
    if (ctrl.shift_ir)
      tdo = ir_tdo;
    else if (sel_idcode)
      tdo = idcode_sr[0];
    else if (sel_data)
      tdo = data_sr[0];
    else
      tdo = bypass_sr;
  end

endmodule

/* src/dbg_test_jtagsm.sv */
//////////////////////////////////////////////////////////////////////
// TAP controller: sixteen-state machine, instruction shift register
// and active instruction latch
//////////////////////////////////////////////////////////////////////

module dbg_test_jtagsm
  import dbg_test_pkg::*;
#(
  parameter int TOTAL_IR_SIZE = 15
) (
  input  logic      tck,
  input  logic      reset_n,
  input  logic      tms,
  input  logic      tdi,
  output tap_ctrl_t ctrl,
  output instr_t    instruction,
  output logic      ir_tdo,
  output logic      shift_dr_next
);

  tap_state_t state;
  tap_state_t next_state;

  logic [TOTAL_IR_SIZE-1:0] ir;

  always_ff @(posedge tck or negedge reset_n)
  begin
    if (!reset_n)
      state <= TAP_TEST_LOGIC_RESET;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = TAP_TEST_LOGIC_RESET;
    case (state)
      TAP_TEST_LOGIC_RESET:
        if (tms)
          next_state = TAP_TEST_LOGIC_RESET;
        else
          next_state = TAP_RUN_TEST_IDLE;
      TAP_RUN_TEST_IDLE:
        if (tms)
          next_state = TAP_SELECT_DR_SCAN;
        else
          next_state = TAP_RUN_TEST_IDLE;
      TAP_SELECT_DR_SCAN:
        if (tms)
          next_state = TAP_SELECT_IR_SCAN;
        else
          next_state = TAP_CAPTURE_DR;
      TAP_CAPTURE_DR:
        if (tms)
          next_state = TAP_EXIT1_DR;
        else
          next_state = TAP_SHIFT_DR;
      TAP_SHIFT_DR:
        if (tms)
          next_state = TAP_EXIT1_DR;
        else
          next_state = TAP_SHIFT_DR;
      TAP_EXIT1_DR:
        if (tms)
          next_state = TAP_UPDATE_DR;
        else
          next_state = TAP_PAUSE_DR;
      TAP_PAUSE_DR:
        if (tms)
          next_state = TAP_EXIT2_DR;
        else
          next_state = TAP_PAUSE_DR;
      TAP_EXIT2_DR:
        if (tms)
          next_state = TAP_UPDATE_DR;
        else
          next_state = TAP_SHIFT_DR;
      TAP_UPDATE_DR:
        if (tms)
          next_state = TAP_SELECT_DR_SCAN;
        else
          next_state = TAP_RUN_TEST_IDLE;
      TAP_SELECT_IR_SCAN:
        if (tms)
          next_state = TAP_TEST_LOGIC_RESET;
        else
          next_state = TAP_CAPTURE_IR;
      TAP_CAPTURE_IR:
        if (tms)
          next_state = TAP_EXIT1_IR;
        else
          next_state = TAP_SHIFT_IR;
      TAP_SHIFT_IR:
        if (tms)
          next_state = TAP_EXIT1_IR;
        else
          next_state = TAP_SHIFT_IR;
      TAP_EXIT1_IR:
        if (tms)
          next_state = TAP_UPDATE_IR;
        else
          next_state = TAP_PAUSE_IR;
      TAP_PAUSE_IR:
        if (tms)
          next_state = TAP_EXIT2_IR;
        else
          next_state = TAP_PAUSE_IR;
      TAP_EXIT2_IR:
        if (tms)
          next_state = TAP_UPDATE_IR;
        else
          next_state = TAP_SHIFT_IR;
      TAP_UPDATE_IR:
        if (tms)
          next_state = TAP_SELECT_DR_SCAN;
        else
          next_state = TAP_RUN_TEST_IDLE;
      default:
        next_state = TAP_TEST_LOGIC_RESET;
    endcase
  end

  // State decodes seen by the data register bank
  assign ctrl.shift_ir         = (state == TAP_SHIFT_IR);
  assign ctrl.shift_dr         = (state == TAP_SHIFT_DR);
  assign ctrl.capture_dr       = (state == TAP_CAPTURE_DR);
  assign ctrl.update_dr        = (state == TAP_UPDATE_DR);
  assign ctrl.update_ir        = (state == TAP_UPDATE_IR);
  assign ctrl.test_logic_reset = (state == TAP_TEST_LOGIC_RESET);

  // Look-ahead into Shift-DR
  assign shift_dr_next = (next_state == TAP_SHIFT_DR);

  // Instruction register with tdi entering at the top
  always_ff @(posedge tck)
  begin
    if (ctrl.test_logic_reset)
      ir <= '0;
    else if (ctrl.shift_ir)
      ir <= {tdi, ir[TOTAL_IR_SIZE-1:1]};
  end

  assign ir_tdo = ir[0];

  // Active instruction changes half a cycle into Update-IR
  always_ff @(negedge tck or negedge reset_n)
  begin
    if (!reset_n)
      instruction <= '0;
    else if (ctrl.update_ir)
      instruction <= ir[INSTR_WIDTH-1:0];
  end

endmodule

/* src/dbg_test_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared JTAG TAP definitions: state encoding, instruction type and
// codes, and the decoded TAP control bundle
//////////////////////////////////////////////////////////////////////

package dbg_test_pkg;

  // IEEE 1149.1 style state encoding
  typedef enum logic [3:0] {
    TAP_EXIT2_DR         = 4'h0,
    TAP_EXIT1_DR         = 4'h1,
    TAP_SHIFT_DR         = 4'h2,
    TAP_PAUSE_DR         = 4'h3,
    TAP_SELECT_IR_SCAN   = 4'h4,
    TAP_UPDATE_DR        = 4'h5,
    TAP_CAPTURE_DR       = 4'h6,
    TAP_SELECT_DR_SCAN   = 4'h7,
    TAP_EXIT2_IR         = 4'h8,
    TAP_EXIT1_IR         = 4'h9,
    TAP_SHIFT_IR         = 4'ha,
    TAP_PAUSE_IR         = 4'hb,
    TAP_RUN_TEST_IDLE    = 4'hc,
    TAP_UPDATE_IR        = 4'hd,
    TAP_CAPTURE_IR       = 4'he,
    TAP_TEST_LOGIC_RESET = 4'hf
  } tap_state_t;

  // Low bits of the instruction register that are decoded
  localparam int INSTR_WIDTH = 7;

  typedef logic [INSTR_WIDTH-1:0] instr_t;

  // Any other code selects BYPASS
  localparam instr_t INSTR_IDCODE = 7'd1;
  localparam instr_t INSTR_DATA   = 7'd2;

  typedef struct packed {
    logic shift_ir;
    logic shift_dr;
    logic capture_dr;
    logic update_dr;
    logic update_ir;
    logic test_logic_reset;
  } tap_ctrl_t;

endpackage
